// File: common/median_pkg.sv
package median_pkg;

    // pixel and coordinate widths
    parameter int PIXEL_W = 8;
    parameter int COORD_W = 10;

    // window geometry
    parameter int WIN_SIZE   = 5;
    parameter int WIN_RADIUS = 2;

    // beats needed before the first window center exists
    parameter int WARMUP_BEATS = 3;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [COORD_W-1:0] coord_t;

    // one window column, top row first
    typedef struct packed {
        pixel_t row_m2;
        pixel_t row_m1;
        pixel_t row_c;
        pixel_t row_p1;
        pixel_t row_p2;
    } column_t;

    // five columns, oldest first
    typedef struct packed {
        column_t col_m2;
        column_t col_m1;
        column_t col_c;
        column_t col_p1;
        column_t col_p2;
    } window_t;

    // raster position of a window center
    typedef struct packed {
        coord_t row;
        coord_t col;
    } pos_t;

endpackage

// File: rtl/column_shifter.sv
module column_shifter (
    input  logic                clk,
    input  logic                rst,
    input  logic                beat_valid_i,
    input  median_pkg::column_t column_i,
    output median_pkg::window_t window_o
);
    import median_pkg::*;

    window_t win_q;
    window_t win_next;

    // every column moves one slot toward the oldest end
    always_comb begin
        win_next.col_m2 = win_q.col_m1;
        win_next.col_m1 = win_q.col_c;
        win_next.col_c  = win_q.col_p1;
        win_next.col_p1 = win_q.col_p2;
        win_next.col_p2 = column_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;
        end else if (beat_valid_i) begin
            win_q <= win_next;
        end
    end

    assign window_o = win_q;

    // an unknown strobe would corrupt the window silently
    a_beat_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(beat_valid_i)
    );

endmodule

// File: rtl/frame_position.sv
module frame_position #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             beat_valid_i,
    output logic             center_valid_o,
    output median_pkg::pos_t center_o
);
    import median_pkg::*;

    localparam int WARM_W = $clog2(WARMUP_BEATS + 1);

    logic [WARM_W-1:0] warm_cnt;
    logic              beat_center;
    coord_t            row_q;
    coord_t            col_q;

    // the beat that fills the center slot for the first time, and every beat after
    assign beat_center = beat_valid_i && (warm_cnt >= WARM_W'(WARMUP_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            warm_cnt <= '0;
        end else if (beat_valid_i && warm_cnt != WARM_W'(WARMUP_BEATS)) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    // next center in raster order
    always_ff @(posedge clk) begin
        if (rst) begin
            row_q <= '0;
            col_q <= '0;
        end else if (beat_center) begin
            if (col_q == coord_t'(COLS - 1)) begin
                col_q <= '0;
                if (row_q == coord_t'(ROWS - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            center_valid_o <= 1'b0;
            center_o       <= '0;
        end else begin
            center_valid_o <= beat_center;
            if (beat_center) begin
                center_o.row <= row_q;
                center_o.col <= col_q;
            end
        end
    end

    a_row_range: assert property (
        @(posedge clk) disable iff (rst)
        row_q < ROWS && center_o.row < ROWS
    );

    a_col_range: assert property (
        @(posedge clk) disable iff (rst)
        col_q < COLS && center_o.col < COLS
    );

endmodule

// File: rtl/border_pad.sv
module border_pad #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  median_pkg::window_t window_i,
    input  logic                center_valid_i,
    input  median_pkg::pos_t    center_i,
    output median_pkg::window_t window_o,
    output logic                window_valid_o,
    output median_pkg::pos_t    center_o
);
    import median_pkg::*;

    // bit k of a flag vector stands for offset k - WIN_RADIUS
    logic [WIN_SIZE-1:0] row_ok;
    logic [WIN_SIZE-1:0] col_ok;
    window_t             win_masked;

    function automatic logic in_range(input coord_t c, input int k, input int limit);
        int p;
        p = int'(c) + k - WIN_RADIUS;
        return (p >= 0) && (p < limit);
    endfunction

    function automatic column_t mask_column(input column_t c, input logic [WIN_SIZE-1:0] keep);
        column_t res;
        res.row_m2 = keep[0] ? c.row_m2 : '0;
        res.row_m1 = keep[1] ? c.row_m1 : '0;
        res.row_c  = keep[2] ? c.row_c  : '0;
        res.row_p1 = keep[3] ? c.row_p1 : '0;
        res.row_p2 = keep[4] ? c.row_p2 : '0;
        return res;
    endfunction

    always_comb begin
        for (int k = 0; k < WIN_SIZE; k++) begin
            row_ok[k] = in_range(center_i.row, k, ROWS);
            col_ok[k] = in_range(center_i.col, k, COLS);
        end
    end

    // a column outside the frame is dropped whole, otherwise only its outside rows
    always_comb begin
        win_masked.col_m2 = mask_column(window_i.col_m2, col_ok[0] ? row_ok : '0);
        win_masked.col_m1 = mask_column(window_i.col_m1, col_ok[1] ? row_ok : '0);
        win_masked.col_c  = mask_column(window_i.col_c,  col_ok[2] ? row_ok : '0);
        win_masked.col_p1 = mask_column(window_i.col_p1, col_ok[3] ? row_ok : '0);
        win_masked.col_p2 = mask_column(window_i.col_p2, col_ok[4] ? row_ok : '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            window_valid_o <= 1'b0;
            window_o       <= '0;
            center_o       <= '0;
        end else begin
            window_valid_o <= center_valid_i;
            if (center_valid_i) begin
                window_o <= win_masked;
                center_o <= center_i;
            end
        end
    end

    // top-left corner, the two leftmost columns lie before column 0
    a_corner_pad: assert property (
        @(posedge clk) disable iff (rst)
        (window_valid_o && center_o == '0) |-> window_o.col_m2 == '0
    );

endmodule

// File: rtl/median_window_top.sv
module median_window_top #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                beat_valid_i,
    input  median_pkg::column_t column_i,
    output median_pkg::window_t window_o,
    output logic                window_valid_o,
    output median_pkg::pos_t    center_o
);
    import median_pkg::*;

    window_t shift_window;
    pos_t    frame_center;
    logic    center_valid;

    // window register and position counter run side by side on the beat
    column_shifter i_column_shifter (
        .clk          (clk),
        .rst          (rst),
        .beat_valid_i (beat_valid_i),
        .column_i     (column_i),
        .window_o     (shift_window)
    );

    frame_position #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) i_frame_position (
        .clk            (clk),
        .rst            (rst),
        .beat_valid_i   (beat_valid_i),
        .center_valid_o (center_valid),
        .center_o       (frame_center)
    );

    // one more register stage for the padded window
    border_pad #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) i_border_pad (
        .clk            (clk),
        .rst            (rst),
        .window_i       (shift_window),
        .center_valid_i (center_valid),
        .center_i       (frame_center),
        .window_o       (window_o),
        .window_valid_o (window_valid_o),
        .center_o       (center_o)
    );

endmodule

// File: tests/tb_median_window.sv
module tb_median_window;
    timeunit 1ns;
    timeprecision 100ps;

    import median_pkg::*;

    localparam int ROWS        = 6;
    localparam int COLS        = 7;
    localparam int FRAME_BEATS = 2 * ROWS * COLS;
    localparam int BURST_BEATS = 20;
    localparam int IDLE_BEATS  = 10;
    localparam int TOTAL_BEATS = WARMUP_BEATS + FRAME_BEATS + BURST_BEATS + IDLE_BEATS;
    localparam int CYCLE_LIMIT = 3 * TOTAL_BEATS + 200;

    logic    clk = 1'b0;
    logic    rst;
    logic    beat_valid_i;
    column_t column_i;
    window_t window_o;
    logic    window_valid_o;
    pos_t    center_o;

    // reference history with hist[0] as the oldest column
    pixel_t  hist [WIN_SIZE][WIN_SIZE];
    int      warm_cnt;
    int      ref_row;
    int      ref_col;

    // expectation for the window that follows one edge later
    logic    pend_valid;
    window_t pend_window;
    pos_t    pend_center;
    logic    pend_inner;

    // expected DUT outputs with the same register timing as the DUT
    logic    exp_valid;
    window_t exp_window;
    pos_t    exp_center;
    logic    exp_inner;

    int      err_count = 0;
    int      inner_checked = 0;
    int      edge_checked = 0;
    int      cycle_cnt = 0;

    median_window_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) i_median_window_top (
        .clk            (clk),
        .rst            (rst),
        .beat_valid_i   (beat_valid_i),
        .column_i       (column_i),
        .window_o       (window_o),
        .window_valid_o (window_valid_o),
        .center_o       (center_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // zero padding straight from the frame bounds
    function automatic window_t padded_window(input int row, input int col);
        logic [WIN_SIZE*WIN_SIZE*PIXEL_W-1:0] flat;
        int r_abs;
        int c_abs;
        int pos;
        flat = '0;
        for (int dc = -WIN_RADIUS; dc <= WIN_RADIUS; dc++) begin
            for (int dr = -WIN_RADIUS; dr <= WIN_RADIUS; dr++) begin
                r_abs = row + dr;
                c_abs = col + dc;
                pos   = ((WIN_RADIUS - dc) * WIN_SIZE + (WIN_RADIUS - dr)) * PIXEL_W;
                if (r_abs >= 0 && r_abs < ROWS && c_abs >= 0 && c_abs < COLS) begin
                    flat[pos +: PIXEL_W] = hist[dc + WIN_RADIUS][dr + WIN_RADIUS];
                end
            end
        end
        return window_t'(flat);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < WIN_SIZE; c++) begin
                for (int r = 0; r < WIN_SIZE; r++) begin
                    hist[c][r] = '0;
                end
            end
            warm_cnt    = 0;
            ref_row     = 0;
            ref_col     = 0;
            pend_valid  = 1'b0;
            pend_window = '0;
            pend_center = '0;
            pend_inner  = 1'b0;
            exp_valid  <= 1'b0;
            exp_window <= '0;
            exp_center <= '0;
            exp_inner  <= 1'b0;
        end else begin
            exp_valid  <= pend_valid;
            exp_window <= pend_window;
            exp_center <= pend_center;
            exp_inner  <= pend_inner;
            if (pend_valid && pend_inner) begin
                inner_checked = inner_checked + 1;
            end else if (pend_valid) begin
                edge_checked = edge_checked + 1;
            end
            pend_valid = 1'b0;
            if (beat_valid_i) begin
                for (int c = 0; c < WIN_SIZE - 1; c++) begin
                    hist[c] = hist[c + 1];
                end
                hist[WIN_SIZE-1][0] = column_i.row_m2;
                hist[WIN_SIZE-1][1] = column_i.row_m1;
                hist[WIN_SIZE-1][2] = column_i.row_c;
                hist[WIN_SIZE-1][3] = column_i.row_p1;
                hist[WIN_SIZE-1][4] = column_i.row_p2;
                if (warm_cnt >= WARMUP_BEATS - 1) begin
                    pend_valid      = 1'b1;
                    pend_window     = padded_window(ref_row, ref_col);
                    pend_center.row = coord_t'(ref_row);
                    pend_center.col = coord_t'(ref_col);
                    pend_inner      = ref_row >= WIN_RADIUS && ref_row < ROWS - WIN_RADIUS &&
                                      ref_col >= WIN_RADIUS && ref_col < COLS - WIN_RADIUS;
                    ref_col = ref_col + 1;
                    if (ref_col == COLS) begin
                        ref_col = 0;
                        ref_row = (ref_row + 1) % ROWS;
                    end
                end
                if (warm_cnt < WARMUP_BEATS) begin
                    warm_cnt = warm_cnt + 1;
                end
            end
        end
    end

    a_valid_match: assert property (
        @(posedge clk) disable iff (rst)
        window_valid_o == exp_valid
    ) else begin
        err_count = err_count + 1;
        $display("Fail window_valid_o expected %h got %h",
                 $sampled(exp_valid), $sampled(window_valid_o));
    end

    a_center_match: assert property (
        @(posedge clk) disable iff (rst)
        exp_valid |-> center_o == exp_center
    ) else begin
        err_count = err_count + 1;
        $display("Fail center_o expected %h got %h", $sampled(exp_center), $sampled(center_o));
    end

    a_inner_window: assert property (
        @(posedge clk) disable iff (rst)
        (exp_valid && exp_inner) |-> window_o == exp_window
    ) else begin
        err_count = err_count + 1;
        $display("Fail window_o expected %h got %h", $sampled(exp_window), $sampled(window_o));
    end

    a_edge_window: assert property (
        @(posedge clk) disable iff (rst)
        (exp_valid && !exp_inner) |-> window_o == exp_window
    ) else begin
        err_count = err_count + 1;
        $display("Fail window_o expected %h got %h", $sampled(exp_window), $sampled(window_o));
    end

    function automatic column_t random_column();
        column_t c;
        c.row_m2 = pixel_t'($urandom);
        c.row_m1 = pixel_t'($urandom);
        c.row_c  = pixel_t'($urandom);
        c.row_p1 = pixel_t'($urandom);
        c.row_p2 = pixel_t'($urandom);
        return c;
    endfunction

    // idle cycles carry random data too that must never enter the window
    task automatic drive_cycle(input logic valid);
        @(negedge clk);
        beat_valid_i = valid;
        column_i     = random_column();
    endtask

    task automatic send_beats(input int count, input logic random_gaps, input int idle_after);
        for (int i = 0; i < count; i++) begin
            if (random_gaps) begin
                while ($urandom_range(0, 3) == 0) begin
                    drive_cycle(1'b0);
                end
            end
            drive_cycle(1'b1);
            for (int j = 0; j < idle_after; j++) begin
                drive_cycle(1'b0);
            end
        end
        // let the last windows leave the two register stages
        repeat (3) drive_cycle(1'b0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished with %0d failures", name, err_count - errs_before);
    endtask

    initial begin
        int errs_before;
        void'($urandom(58));
        rst          = 1'b1;
        beat_valid_i = 1'b0;
        column_i     = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        errs_before = err_count;
        send_beats(WARMUP_BEATS, 1'b1, 0);
        report_test("warmup", errs_before);

        errs_before = err_count;
        send_beats(FRAME_BEATS, 1'b1, 0);
        report_test("raster_frames", errs_before);

        errs_before = err_count;
        send_beats(BURST_BEATS, 1'b0, 0);
        report_test("back_to_back", errs_before);

        errs_before = err_count;
        send_beats(IDLE_BEATS, 1'b0, 3);
        report_test("idle_gaps", errs_before);

        if (inner_checked == 0) begin
            $display("no window with an interior center was checked");
            err_count = err_count + 1;
        end
        if (edge_checked == 0) begin
            $display("no window with a border center was checked");
            err_count = err_count + 1;
        end

        $display("tests 4, interior windows %0d, border windows %0d, failures %0d",
                 inner_checked, edge_checked, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
common/median_pkg.sv
rtl/column_shifter.sv
rtl/frame_position.sv
rtl/border_pad.sv
rtl/median_window_top.sv
tests/tb_median_window.sv

// File: run.sh
#!/bin/sh
# build and run the median window testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_median_window -f all.f -o sim_median_window ||
    { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_median_window 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST PASS" && echo "run passed" ||
    { echo "run failed"; exit 1; }
